//--- mem_params.svh
// Memory system parameters
// Word width, cache block size, main memory read latency and depth
// shared by the package, the fill engines and the memory model

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Width of one memory and cache word in bits
`define WORD_WIDTH 16

// Words in one 16-byte cache block
`define WORDS_PER_BLOCK 8

// Cycles from a read request to its returned data
`define MEM_LATENCY 4

// Depth of the main memory in words
`define MEM_WORDS 1024

`endif

//--- cache_pkg.sv
// Cache refill package
// Word type, the two-way decoded byte address and the fill engine states

`default_nettype none

`include "mem_params.svh"

package cache_pkg;

    localparam int ADDR_BITS   = 16;                               // Byte address width
    localparam int OFFSET_BITS = $clog2(`WORDS_PER_BLOCK);         // Word offset inside a block
    localparam int BLOCK_BITS  = ADDR_BITS - OFFSET_BITS - 1;      // Block number above the offset

    typedef logic [`WORD_WIDTH-1:0] data_word_t;                   // One memory or cache word

    // One byte address seen either flat or split into block fields
    typedef union packed {
        logic [ADDR_BITS-1:0] flat;                                // Used by muxes and memory indexing
        struct packed {
            logic [BLOCK_BITS-1:0]  block;                         // Block number
            logic [OFFSET_BITS-1:0] offset;                        // Word within the block
            logic                   byte_sel;                      // Byte within the word
        } blk;
    } mem_addr_u;

    // Fill engine states
    typedef enum logic [1:0] {
        IDLE = 2'd0,                                               // Waiting for a start pulse
        FILL = 2'd1,                                               // Issuing word requests
        DONE = 2'd2                                                // All requests out and draining returns
    } fill_state_e;

endpackage

`default_nettype wire

//--- cache_fill_fsm.sv
// Cache fill engine
// Latches a miss address and streams one block out of a pipelined memory
// with several reads in flight, reporting each returned word as a data
// array write and the last word as a tag write

`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module cache_fill_fsm import cache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      start,             // One cycle pulse from the arbiter
    input  mem_addr_u miss_addr,         // Address that missed in the cache
    input  logic      mem_data_valid,    // Returned word valid for this engine
    output logic      busy,              // High from the cycle after start until the block is in
    output logic      req_valid,         // Word read request toward memory
    output mem_addr_u req_addr,          // Address of the requested word
    output mem_addr_u fill_addr,         // Address of the word being written into the cache
    output logic      write_data_array,  // Data array write strobe
    output logic      write_tag_array    // Tag array write strobe with the last word
);

    localparam logic [OFFSET_BITS-1:0] LAST_WORD = OFFSET_BITS'(`WORDS_PER_BLOCK - 1);

    fill_state_e            state;       // Engine state
    logic [BLOCK_BITS-1:0]  fill_block;  // Block number latched on start
    logic [OFFSET_BITS-1:0] req_cnt;     // Offset of the next request
    logic [OFFSET_BITS-1:0] rsp_cnt;     // Offset of the next returned word
    logic                   last_rsp;    // Final word of the block is returning

    assign busy             = (state != IDLE);
    assign write_data_array = busy & mem_data_valid;                 // Every return is written straight in
    assign last_rsp         = write_data_array & (rsp_cnt == LAST_WORD);
    assign write_tag_array  = last_rsp;                              // Tag goes in with the eighth word

    // Requests and returns run on their own counters so they overlap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            req_cnt   <= '0;
            rsp_cnt   <= '0;
            req_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    req_valid <= 1'b0;
                    if (start) begin
                        state   <= FILL;                             // Busy rises next cycle
                        req_cnt <= '0;
                        rsp_cnt <= '0;
                    end
                end
                FILL: begin
                    req_valid <= 1'b1;                               // Registered request for offset req_cnt
                    req_cnt   <= req_cnt + 1'b1;
                    if (req_cnt == LAST_WORD) begin
                        state <= DONE;                               // Eighth request goes out next cycle
                    end
                end
                DONE: begin
                    req_valid <= 1'b0;
                    if (last_rsp) begin
                        state <= IDLE;                               // Busy falls after the eighth word
                    end
                end
                default: begin
                    state     <= IDLE;
                    req_valid <= 1'b0;
                end
            endcase
            if (write_data_array) begin
                rsp_cnt <= rsp_cnt + 1'b1;                           // Returns arrive in request order
            end
        end
    end

    // Address payload registers
    always_ff @(posedge clk) begin
        if (start && (state == IDLE)) begin
            fill_block <= miss_addr.blk.block;                       // Keep only the block number
        end
        if (state == FILL) begin
            req_addr.blk.block    <= fill_block;
            req_addr.blk.offset   <= req_cnt;                        // Steps through offsets 0 to 7
            req_addr.blk.byte_sel <= 1'b0;                           // Requests are word aligned
        end
    end

    // The word being written back takes its offset from the response counter
    always_comb begin
        fill_addr.blk.block    = fill_block;
        fill_addr.blk.offset   = rsp_cnt;
        fill_addr.blk.byte_sel = 1'b0;
    end

endmodule

`default_nettype wire

//--- cache_arbiter.sv
// Cache arbiter
// Grants the shared main memory to one fill engine at a time with
// instruction cache priority, stalls the CPU while a fill is pending and
// passes data cache write-through stores when nothing is pending

`timescale 1ns/1ps
`default_nettype none

module cache_arbiter import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    output logic       stall_n,                  // Low while any fill is pending

    input  mem_addr_u  icache_addr,              // Instruction cache lookup address
    input  logic       icache_miss_detected,     // Instruction cache miss level
    output data_word_t icache_fill_data,         // Word being filled into the instruction cache
    output mem_addr_u  icache_fill_addr,         // Address of that word
    output logic       icache_write_data_array,  // Instruction cache data array strobe
    output logic       icache_write_tag_array,   // Instruction cache tag array strobe
    output logic       icache_fsm_busy,          // Instruction fill in progress

    input  mem_addr_u  dcache_addr,              // Data cache lookup address
    input  logic       dcache_miss_detected,     // Data cache miss level
    output data_word_t dcache_fill_data,         // Word being filled into the data cache
    output mem_addr_u  dcache_fill_addr,         // Address of that word
    output logic       dcache_write_data_array,  // Data cache data array strobe
    output logic       dcache_write_tag_array,   // Data cache tag array strobe
    output logic       dcache_fsm_busy,          // Data fill in progress
    input  mem_addr_u  dcache_write_addr,        // Write-through store address
    input  data_word_t dcache_write_data,        // Write-through store data
    input  logic       dcache_write_enable,      // Write-through store request

    output mem_addr_u  mainmem_addr,             // Shared memory address
    output data_word_t mainmem_write_data,       // Shared memory write data
    output logic       mainmem_rd,               // Memory read request
    output logic       mainmem_wr,               // Memory write request
    input  data_word_t mainmem_read_data,        // Returned read word
    input  logic       mainmem_data_valid        // Returned read word is valid
);

    logic      grant_dcache;       // High while the data cache owns the read path
    logic      fill_active;        // Granted engine is still busy
    logic      fill_pending;       // A miss is waiting or a fill is running
    logic      icache_start;       // Start pulse for the instruction fill
    logic      dcache_start;       // Start pulse for the data fill
    logic      icache_req_valid;
    logic      dcache_req_valid;
    mem_addr_u icache_req_addr;
    mem_addr_u dcache_req_addr;
    logic      icache_data_valid;  // Memory valid steered to the instruction engine
    logic      dcache_data_valid;  // Memory valid steered to the data engine

    assign fill_active  = grant_dcache ? dcache_fsm_busy : icache_fsm_busy;
    assign icache_start = icache_miss_detected & ~icache_fsm_busy & ~fill_active;
    assign dcache_start = dcache_miss_detected & ~dcache_fsm_busy & ~fill_active
                        & ~icache_start;                  // Instruction cache wins a tie

    // The caches hold their miss levels while stalled so the stall covers the whole fill
    assign fill_pending = icache_miss_detected | dcache_miss_detected
                        | icache_fsm_busy | dcache_fsm_busy;
    assign stall_n      = ~fill_pending;

    // Grant owner changes only when a new fill starts
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            grant_dcache <= 1'b0;
        end else if (icache_start) begin
            grant_dcache <= 1'b0;
        end else if (dcache_start) begin
            grant_dcache <= 1'b1;
        end
    end

    cache_fill_fsm icache_fill (
        .clk              (clk),
        .arst_n           (arst_n),
        .start            (icache_start),
        .miss_addr        (icache_addr),
        .mem_data_valid   (icache_data_valid),
        .busy             (icache_fsm_busy),
        .req_valid        (icache_req_valid),
        .req_addr         (icache_req_addr),
        .fill_addr        (icache_fill_addr),
        .write_data_array (icache_write_data_array),
        .write_tag_array  (icache_write_tag_array)
    );

    cache_fill_fsm dcache_fill (
        .clk              (clk),
        .arst_n           (arst_n),
        .start            (dcache_start),
        .miss_addr        (dcache_addr),
        .mem_data_valid   (dcache_data_valid),
        .busy             (dcache_fsm_busy),
        .req_valid        (dcache_req_valid),
        .req_addr         (dcache_req_addr),
        .fill_addr        (dcache_fill_addr),
        .write_data_array (dcache_write_data_array),
        .write_tag_array  (dcache_write_tag_array)
    );

    // Fill requests own the address while pending and stores use it otherwise
    always_comb begin
        if (fill_pending) begin
            mainmem_addr.flat = grant_dcache ? dcache_req_addr.flat : icache_req_addr.flat;
        end else begin
            mainmem_addr.flat = dcache_write_addr.flat;
        end
    end

    assign mainmem_rd         = grant_dcache ? dcache_req_valid : icache_req_valid;
    assign mainmem_wr         = dcache_write_enable & ~fill_pending;  // Stores wait out a stall
    assign mainmem_write_data = dcache_write_data;

    assign icache_data_valid  = mainmem_data_valid & ~grant_dcache;
    assign dcache_data_valid  = mainmem_data_valid & grant_dcache;
    assign icache_fill_data   = mainmem_read_data;                  // Strobes pick the cache that writes
    assign dcache_fill_data   = mainmem_read_data;

endmodule

`default_nettype wire

//--- main_memory.sv
// Main memory model
// Word-addressed memory with single-cycle writes and a fixed-latency
// read pipeline, so back-to-back reads return in order

`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module main_memory import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  mem_addr_u  addr,        // Byte address of the access
    input  data_word_t write_data,  // Store data
    input  logic       rd,          // Read request
    input  logic       wr,          // Write request
    output data_word_t read_data,   // Word returned MEM_LATENCY cycles after rd
    output logic       data_valid   // Valid for read_data
);

    localparam int IDX_BITS = $clog2(`MEM_WORDS);

    data_word_t          mem [`MEM_WORDS];         // Storage array
    data_word_t          pipe_data [`MEM_LATENCY]; // Read data in flight
    logic [`MEM_LATENCY-1:0] pipe_valid;           // Valid bits in flight
    logic [IDX_BITS-1:0] word_idx;                 // Word index from the byte address

    assign word_idx = addr.flat[IDX_BITS:1];       // Drop the byte bit

    // Storage is cleared at reset and written at the clock edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr) begin
            mem[word_idx] <= write_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[`MEM_LATENCY-2:0], rd};  // Shift a request toward the output
        end
    end

    always_ff @(posedge clk) begin
        pipe_data[0] <= mem[word_idx];                         // Sampled on every edge and tagged by valid
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign read_data  = pipe_data[`MEM_LATENCY-1];
    assign data_valid = pipe_valid[`MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- mem_subsystem_top.sv
// Memory subsystem top level
// Joins the cache arbiter with the shared main memory behind it

`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top import cache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    output logic       stall_n,

    input  mem_addr_u  icache_addr,
    input  logic       icache_miss_detected,
    output data_word_t icache_fill_data,
    output mem_addr_u  icache_fill_addr,
    output logic       icache_write_data_array,
    output logic       icache_write_tag_array,
    output logic       icache_fsm_busy,

    input  mem_addr_u  dcache_addr,
    input  logic       dcache_miss_detected,
    output data_word_t dcache_fill_data,
    output mem_addr_u  dcache_fill_addr,
    output logic       dcache_write_data_array,
    output logic       dcache_write_tag_array,
    output logic       dcache_fsm_busy,
    input  mem_addr_u  dcache_write_addr,
    input  data_word_t dcache_write_data,
    input  logic       dcache_write_enable
);

    mem_addr_u  mainmem_addr;        // Fill request or store address
    data_word_t mainmem_write_data;  // Store data
    logic       mainmem_rd;          // Fill word request
    logic       mainmem_wr;          // Store request
    data_word_t mainmem_read_data;   // Returned fill word
    logic       mainmem_data_valid;  // Returned fill word valid

    cache_arbiter u_arbiter (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .stall_n                 (stall_n),
        .icache_addr             (icache_addr),
        .icache_miss_detected    (icache_miss_detected),
        .icache_fill_data        (icache_fill_data),
        .icache_fill_addr        (icache_fill_addr),
        .icache_write_data_array (icache_write_data_array),
        .icache_write_tag_array  (icache_write_tag_array),
        .icache_fsm_busy         (icache_fsm_busy),
        .dcache_addr             (dcache_addr),
        .dcache_miss_detected    (dcache_miss_detected),
        .dcache_fill_data        (dcache_fill_data),
        .dcache_fill_addr        (dcache_fill_addr),
        .dcache_write_data_array (dcache_write_data_array),
        .dcache_write_tag_array  (dcache_write_tag_array),
        .dcache_fsm_busy         (dcache_fsm_busy),
        .dcache_write_addr       (dcache_write_addr),
        .dcache_write_data       (dcache_write_data),
        .dcache_write_enable     (dcache_write_enable),
        .mainmem_addr            (mainmem_addr),
        .mainmem_write_data      (mainmem_write_data),
        .mainmem_rd              (mainmem_rd),
        .mainmem_wr              (mainmem_wr),
        .mainmem_read_data       (mainmem_read_data),
        .mainmem_data_valid      (mainmem_data_valid)
    );

    main_memory u_main_memory (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (mainmem_addr),
        .write_data (mainmem_write_data),
        .rd         (mainmem_rd),
        .wr         (mainmem_wr),
        .read_data  (mainmem_read_data),
        .data_valid (mainmem_data_valid)
    );

endmodule

`default_nettype wire

//--- tb_mem_subsystem.sv
// Memory subsystem testbench
// Plays both caches from a table of stores and misses, mirrors main memory
// in a reference array and checks every fill word, strobe and stall

`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsystem import cache_pkg::*; ();

    localparam int NUM_STEPS   = 13;
    localparam int FILL_CYC    = 1 + `WORDS_PER_BLOCK + `MEM_LATENCY;  // Start to busy low
    localparam int MISS_LIMIT  = 2 * FILL_CYC + 4;                     // Longest stall of one step
    localparam int WATCHDOG_NS = NUM_STEPS * MISS_LIMIT * 100;
    localparam logic [15:0] BLOCK_MASK = ~16'(2 * `WORDS_PER_BLOCK - 1);

    typedef enum logic [2:0] {
        OP_STORE,        // One store of the table word
        OP_STORE_BLOCK,  // A whole block of random words
        OP_IMISS,
        OP_DMISS,
        OP_BOTH          // Data column holds the data cache miss address
    } op_e;

    logic       clk;
    logic       arst_n;
    logic       stall_n;
    mem_addr_u  icache_addr;
    logic       icache_miss_detected;
    data_word_t icache_fill_data;
    mem_addr_u  icache_fill_addr;
    logic       icache_write_data_array;
    logic       icache_write_tag_array;
    logic       icache_fsm_busy;
    mem_addr_u  dcache_addr;
    logic       dcache_miss_detected;
    data_word_t dcache_fill_data;
    mem_addr_u  dcache_fill_addr;
    logic       dcache_write_data_array;
    logic       dcache_write_tag_array;
    logic       dcache_fsm_busy;
    mem_addr_u  dcache_write_addr;
    data_word_t dcache_write_data;
    logic       dcache_write_enable;

    op_e         step_op   [NUM_STEPS];
    logic [15:0] step_addr [NUM_STEPS];
    data_word_t  step_data [NUM_STEPS];
    data_word_t  ref_mem   [`MEM_WORDS];  // Mirror of main memory
    integer      seed = 32'h7364_9243;

    fill_state_e icache_fill_state;  // Fill engine states shown when the run times out
    fill_state_e dcache_fill_state;

    mem_subsystem_top UUT (
        .clk                     (clk),
        .arst_n                  (arst_n),
        .stall_n                 (stall_n),
        .icache_addr             (icache_addr),
        .icache_miss_detected    (icache_miss_detected),
        .icache_fill_data        (icache_fill_data),
        .icache_fill_addr        (icache_fill_addr),
        .icache_write_data_array (icache_write_data_array),
        .icache_write_tag_array  (icache_write_tag_array),
        .icache_fsm_busy         (icache_fsm_busy),
        .dcache_addr             (dcache_addr),
        .dcache_miss_detected    (dcache_miss_detected),
        .dcache_fill_data        (dcache_fill_data),
        .dcache_fill_addr        (dcache_fill_addr),
        .dcache_write_data_array (dcache_write_data_array),
        .dcache_write_tag_array  (dcache_write_tag_array),
        .dcache_fsm_busy         (dcache_fsm_busy),
        .dcache_write_addr       (dcache_write_addr),
        .dcache_write_data       (dcache_write_data),
        .dcache_write_enable     (dcache_write_enable)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        icache_fill_state = UUT.u_arbiter.icache_fill.state;
        dcache_fill_state = UUT.u_arbiter.dcache_fill.state;
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Instruction fill engine in %s, data fill engine in %s",
                 icache_fill_state.name(), dcache_fill_state.name());
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

    function automatic int word_index(input logic [15:0] byte_addr);
        return (byte_addr >> 1) % `MEM_WORDS;  // Memory is word addressed and wraps at its depth
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("At %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input data_word_t expected,
                              input data_word_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_u expected,
                              input mem_addr_u actual);
        if (actual.flat !== expected.flat) begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name,
                     expected.flat, actual.flat);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %b got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic set_step(input int s, input op_e op, input logic [15:0] addr,
                            input data_word_t data);
        step_op[s]   = op;
        step_addr[s] = addr;
        step_data[s] = data;
    endtask

    task automatic load_table();
        set_step(0,  OP_STORE_BLOCK, 16'h0040, 16'h0000);
        set_step(1,  OP_STORE,       16'h0046, 16'hBEEF);  // Overwrites offset 3 of that block
        set_step(2,  OP_IMISS,       16'h004A, 16'h0000);
        set_step(3,  OP_DMISS,       16'h0047, 16'h0000);  // Odd byte inside the same block
        set_step(4,  OP_STORE_BLOCK, 16'h0100, 16'h0000);
        set_step(5,  OP_STORE_BLOCK, 16'h0230, 16'h0000);
        set_step(6,  OP_BOTH,        16'h0104, 16'h023E);
        set_step(7,  OP_IMISS,       16'h0230, 16'h0000);
        set_step(8,  OP_DMISS,       16'h0100, 16'h0000);
        set_step(9,  OP_IMISS,       16'h0500, 16'h0000);  // Never written so all words are zero
        set_step(10, OP_STORE,       16'h0502, 16'h1234);
        set_step(11, OP_DMISS,       16'h0500, 16'h0000);
        set_step(12, OP_BOTH,        16'h0040, 16'h0500);
    endtask

    // Drive one write-through store while no fill is pending
    task automatic store_word(input logic [15:0] addr, input data_word_t data);
        @(posedge clk);
        #5;
        dcache_write_addr.flat = addr;
        dcache_write_data      = data;
        dcache_write_enable    = 1'b1;
        @(negedge clk);
        check_bit("stall_n", 1'b1, stall_n);
        @(posedge clk);
        ref_mem[word_index(addr)] = data;  // The store lands at this edge
        #5;
        dcache_write_enable = 1'b0;
    endtask

    // One returned word must be word k of the missing block
    task automatic check_fill_word(input string cache, input logic [15:0] miss, input int k,
                                   input mem_addr_u fill_addr, input data_word_t fill_data,
                                   input logic tag);
        mem_addr_u exp_addr;
        exp_addr.flat = (miss & BLOCK_MASK) + 16'(2 * k);
        check_addr({cache, "_fill_addr"}, exp_addr, fill_addr);
        check_word({cache, "_fill_data"}, ref_mem[word_index(exp_addr.flat)], fill_data);
        check_bit({cache, "_write_tag_array"}, k == `WORDS_PER_BLOCK - 1, tag);
    endtask

    // Raise one or both misses and follow the fills until stall_n rises
    task automatic run_miss(input logic do_i, input logic do_d,
                            input logic [15:0] i_addr, input logic [15:0] d_addr);
        int   cyc;
        int   i_words;
        int   d_words;
        logic i_done;
        logic d_done;
        cyc     = 0;
        i_words = 0;
        d_words = 0;
        i_done  = !do_i;
        d_done  = !do_d;
        @(posedge clk);
        #5;
        icache_addr.flat     = i_addr;
        icache_miss_detected = do_i;
        dcache_addr.flat     = d_addr;
        dcache_miss_detected = do_d;
        // A store offered during the stall must not reach memory, later fills would see it
        dcache_write_addr.flat = (do_d ? d_addr : i_addr) & BLOCK_MASK;
        dcache_write_data      = data_word_t'($random(seed));
        dcache_write_enable    = 1'b1;
        while (!(i_done && d_done)) begin
            if (cyc > MISS_LIMIT) begin
                report_problem($sformatf("Fill did not complete within %0d cycles", MISS_LIMIT));
            end
            @(negedge clk);
            check_bit("stall_n", 1'b0, stall_n);  // Low from the miss cycle to the last tag write
            if (cyc == 1) begin
                check_bit(do_i ? "icache_fsm_busy" : "dcache_fsm_busy", 1'b1,
                          do_i ? icache_fsm_busy : dcache_fsm_busy);
            end
            if (i_done) begin
                check_bit("icache_write_data_array", 1'b0, icache_write_data_array);
                check_bit("icache_write_tag_array", 1'b0, icache_write_tag_array);
            end else if (icache_write_data_array) begin
                check_fill_word("icache", i_addr, i_words, icache_fill_addr, icache_fill_data,
                                icache_write_tag_array);
                i_words++;
            end else begin
                check_bit("icache_write_tag_array", 1'b0, icache_write_tag_array);
            end
            // A data fill may only write once the instruction fill is complete
            if (d_done || !i_done) begin
                check_bit("dcache_write_data_array", 1'b0, dcache_write_data_array);
                check_bit("dcache_write_tag_array", 1'b0, dcache_write_tag_array);
            end else if (dcache_write_data_array) begin
                check_fill_word("dcache", d_addr, d_words, dcache_fill_addr, dcache_fill_data,
                                dcache_write_tag_array);
                d_words++;
            end else begin
                check_bit("dcache_write_tag_array", 1'b0, dcache_write_tag_array);
            end
            @(posedge clk);
            #5;
            if (!i_done && i_words == `WORDS_PER_BLOCK) begin
                i_done               = 1'b1;
                icache_miss_detected = 1'b0;  // Block is in so the cache hits from now on
            end
            if (!d_done && d_words == `WORDS_PER_BLOCK) begin
                d_done               = 1'b1;
                dcache_miss_detected = 1'b0;
            end
            cyc++;
        end
        dcache_write_enable = 1'b0;  // The held store is withdrawn before any edge with stall_n high
        @(negedge clk);
        check_bit("stall_n", 1'b1, stall_n);
        check_bit("icache_fsm_busy", 1'b0, icache_fsm_busy);
        check_bit("dcache_fsm_busy", 1'b0, dcache_fsm_busy);
        if (!(do_i && do_d) && cyc != FILL_CYC + 1) begin
            report_problem($sformatf("stall_n rose %0d cycles after the miss instead of %0d",
                                     cyc, FILL_CYC + 1));
        end
    endtask

    initial begin
        arst_n               = 1'b0;
        icache_addr          = '0;
        icache_miss_detected = 1'b0;
        dcache_addr          = '0;
        dcache_miss_detected = 1'b0;
        dcache_write_addr    = '0;
        dcache_write_data    = '0;
        dcache_write_enable  = 1'b0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_mem[i] = '0;  // Memory clears at reset
        end
        load_table();
        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("stall_n", 1'b1, stall_n);
        check_bit("icache_fsm_busy", 1'b0, icache_fsm_busy);
        check_bit("dcache_fsm_busy", 1'b0, dcache_fsm_busy);
        check_bit("icache_write_data_array", 1'b0, icache_write_data_array);
        check_bit("icache_write_tag_array", 1'b0, icache_write_tag_array);
        check_bit("dcache_write_data_array", 1'b0, dcache_write_data_array);
        check_bit("dcache_write_tag_array", 1'b0, dcache_write_tag_array);
        for (int s = 0; s < NUM_STEPS; s++) begin
            case (step_op[s])
                OP_STORE:       store_word(step_addr[s], step_data[s]);
                OP_STORE_BLOCK: begin
                    for (int k = 0; k < `WORDS_PER_BLOCK; k++) begin
                        store_word(step_addr[s] + 16'(2 * k), data_word_t'($random(seed)));
                    end
                end
                OP_IMISS:       run_miss(1'b1, 1'b0, step_addr[s], 16'h0000);
                OP_DMISS:       run_miss(1'b0, 1'b1, 16'h0000, step_addr[s]);
                OP_BOTH:        run_miss(1'b1, 1'b1, step_addr[s], step_data[s]);
                default:        report_problem("Unknown operation in the stimulus table");
            endcase
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
cache_pkg.sv
cache_fill_fsm.sv
cache_arbiter.sv
main_memory.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

export_include_dirs:
  - .

sources:
  - cache_pkg.sv
  - cache_fill_fsm.sv
  - cache_arbiter.sv
  - main_memory.sv
  - mem_subsystem_top.sv
  - target: test
    files:
      - tb_mem_subsystem.sv
